// File: Bender.yml
package:
  name: cpu16_decode

sources:
  - design/cpu16_pkg.sv
  - design/if_id_reg.sv
  - design/reg_file.sv
  - design/control_decode.sv
  - design/hazard_unit.sv
  - design/id_stage.sv
  - design/decode_top.sv
  - target: test
    files:
      - verif/decode_chk.sv
      - verif/decode_tb.sv

// File: cpu16_decode.f
design/cpu16_pkg.sv
design/if_id_reg.sv
design/reg_file.sv
design/control_decode.sv
design/hazard_unit.sv
design/id_stage.sv
design/decode_top.sv
verif/decode_chk.sv
verif/decode_tb.sv

// File: design/control_decode.sv
// Opcode control decoder
`timescale 1ns/100ps
`default_nettype none

module control_decode (
    input  wire cpu16_pkg::opcode_e opcode,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    mem_read,
    output logic                    mem_to_reg,  // Writeback from memory
    output logic                    alu_src,     // Immediate operand
    output cpu16_pkg::alu_op_e      alu_op,
    output logic                    branch,
    output logic                    call,
    output logic                    ret,
    output logic                    load_half,
    output logic                    half_spec,   // 0 for LHB, 1 for LLB
    output logic                    halt,
    output logic                    data_reg,    // Port 1 reads DS
    output logic                    stack_reg,   // Port 1 reads SP
    output logic                    rt_src,      // Port 2 reads dest field
    output logic                    imm8_sel,    // Extend the 8-bit immediate
    output logic                    reads_rt     // Port 2 is a real source
);
    import cpu16_pkg::*;

    always_comb begin
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        mem_read   = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        alu_op     = alu_pass;
        branch     = 1'b0;
        call       = 1'b0;
        ret        = 1'b0;
        load_half  = 1'b0;
        half_spec  = 1'b0;
        halt       = 1'b0;
        data_reg   = 1'b0;
        stack_reg  = 1'b0;
        rt_src     = 1'b0;
        imm8_sel   = 1'b0;
        reads_rt   = 1'b0;
        case (opcode)
            op_add, op_sub, op_nand, op_xor: begin
                reg_write = 1'b1;
                reads_rt  = 1'b1;
                case (opcode)
                    op_add:  alu_op = alu_add;
                    op_sub:  alu_op = alu_sub;
                    op_nand: alu_op = alu_nand;
                    default: alu_op = alu_xor;
                endcase
            end
            op_addi, op_sll, op_srl, op_sra: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;  // 4-bit immediate
                case (opcode)
                    op_addi: alu_op = alu_add;
                    op_sll:  alu_op = alu_sll;
                    op_srl:  alu_op = alu_srl;
                    default: alu_op = alu_sra;
                endcase
            end
            op_lw: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
                alu_op     = alu_add;  // DS + offset
                data_reg   = 1'b1;
                imm8_sel   = 1'b1;
            end
            op_sw: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_add;
                data_reg  = 1'b1;
                imm8_sel  = 1'b1;
                rt_src    = 1'b1;  // Store data from dest field
                reads_rt  = 1'b1;
            end
            op_lhb, op_llb: begin
                reg_write = 1'b1;
                load_half = 1'b1;
                alu_src   = 1'b1;
                alu_op    = alu_pass;
                imm8_sel  = 1'b1;
                rt_src    = 1'b1;  // Other half comes from the dest reg
                reads_rt  = 1'b1;
                half_spec = (opcode == op_llb);
            end
            op_b: begin
                branch = 1'b1;
                alu_op = alu_sub;
            end
            op_call: begin
                call      = 1'b1;
                mem_write = 1'b1;  // Push return address
                stack_reg = 1'b1;
                alu_op    = alu_sub;
            end
            op_ret: begin
                ret       = 1'b1;
                mem_read  = 1'b1;  // Pop return address
                stack_reg = 1'b1;
                alu_op    = alu_add;
            end
            default: begin
                halt   = 1'b1;  // op_hlt
                alu_op = alu_pass;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/cpu16_pkg.sv
// CPU16 decode package
`default_nettype none

package cpu16_pkg;

    // Datapath and register file sizes
    localparam int data_width     = 16;
    localparam int reg_addr_width = 4;
    localparam int num_regs       = 16;

    // Special registers
    localparam logic [reg_addr_width-1:0] zero_reg = 4'd0;  // Hardwired zero
    localparam logic [reg_addr_width-1:0] ds_reg   = 4'd14; // Data segment base
    localparam logic [reg_addr_width-1:0] sp_reg   = 4'd15; // Stack pointer
    localparam logic [data_width-1:0] sp_reset_value = 16'hFFFF;

    // Instruction fields as low index plus width
    localparam int opcode_lsb = 12;
    localparam int opcode_w   = 4;
    localparam int rd_lsb     = 8;  // Dest or load/store register
    localparam int rd_w       = 4;
    localparam int cond_lsb   = 8;  // Branch condition
    localparam int cond_w     = 3;
    localparam int rs_lsb     = 4;
    localparam int rs_w       = 4;
    localparam int rt_lsb     = 0;
    localparam int rt_w       = 4;
    localparam int imm4_lsb   = 0;  // Arithmetic/shift immediate
    localparam int imm4_w     = 4;
    localparam int imm8_lsb   = 0;  // Load/store and half-load immediate
    localparam int imm8_w     = 8;
    localparam int target_lsb = 0;  // Call target
    localparam int target_w   = 12;

    // Opcode map in encoding order
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_nand,
        op_xor,
        op_addi,
        op_sll,
        op_srl,
        op_sra,
        op_lw,
        op_sw,
        op_lhb,
        op_llb,
        op_b,
        op_call,
        op_ret,
        op_hlt
    } opcode_e;

    // ALU operations; pass is the bubble code
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_nand,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass   // 3'b111
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/decode_top.sv
// CPU16 decode top level
`timescale 1ns/100ps
`default_nettype none

module decode_top (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic [cpu16_pkg::data_width-1:0]     instr,
    input  wire logic [cpu16_pkg::data_width-1:0]     pc,
    input  wire logic                                pc_update,
    input  wire logic                                reg_write_in,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] wb_reg,
    input  wire logic [cpu16_pkg::data_width-1:0]     wb_data,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] id_ex_rd,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] ex_mem_rd,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] mem_wb_rd,
    output logic reg_write, mem_write, mem_read, mem_to_reg, alu_src,
    output cpu16_pkg::alu_op_e alu_op,
    output logic branch, call, ret, load_half, half_spec, halt,
    output logic [cpu16_pkg::data_width-1:0]     read_data_1,
    output logic [cpu16_pkg::data_width-1:0]     read_data_2,
    output logic [cpu16_pkg::data_width-1:0]     sign_ext,
    output logic [cpu16_pkg::imm4_w-1:0]         arith_imm,
    output logic [cpu16_pkg::imm8_w-1:0]         ls_imm,
    output logic [cpu16_pkg::rd_w-1:0]           ls_reg,
    output logic [cpu16_pkg::cond_w-1:0]         branch_cond,
    output logic [cpu16_pkg::target_w-1:0]       call_target,
    output logic [cpu16_pkg::data_width-1:0]     pc_out,
    output logic                                 stall,
    output logic                                 pc_hazard
);
    import cpu16_pkg::*;

    logic [data_width-1:0] id_instr;  // Held word
    logic [data_width-1:0] id_pc;
    logic                  id_valid;

    // Stall and pc_hazard loop back to hold the buffer
    if_id_reg u_if_id (
        .clk(clk), .rst(rst), .stall(stall), .pc_hazard(pc_hazard),
        .pc_update(pc_update), .instr(instr), .pc(pc),
        .id_instr(id_instr), .id_pc(id_pc), .id_valid(id_valid)
    );

    id_stage u_id (
        .clk(clk), .rst(rst), .instr(id_instr), .pc(id_pc), .valid(id_valid),
        .reg_write_in(reg_write_in), .wb_reg(wb_reg), .wb_data(wb_data),
        .id_ex_rd(id_ex_rd), .ex_mem_rd(ex_mem_rd), .mem_wb_rd(mem_wb_rd),
        .pc_update(pc_update), .reg_write(reg_write), .mem_write(mem_write),
        .mem_read(mem_read), .mem_to_reg(mem_to_reg), .alu_src(alu_src),
        .alu_op(alu_op), .branch(branch), .call(call), .ret(ret),
        .load_half(load_half), .half_spec(half_spec), .halt(halt),
        .read_data_1(read_data_1), .read_data_2(read_data_2), .sign_ext(sign_ext),
        .arith_imm(arith_imm), .ls_imm(ls_imm), .ls_reg(ls_reg),
        .branch_cond(branch_cond), .call_target(call_target), .pc_out(pc_out),
        .stall(stall), .pc_hazard(pc_hazard)
    );

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// Data and control-flow hazard detection
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] src_1,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] src_2,
    input  wire logic                                uses_src_2,
    input  wire logic                                valid,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] id_ex_rd,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] ex_mem_rd,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] mem_wb_rd,
    input  wire logic                                flow_change,  // Branch, call or ret
    input  wire logic                                pc_update,
    output logic                                     stall,
    output logic                                     pc_hazard
);
    import cpu16_pkg::*;

    logic hit_1;
    logic hit_2;

    // Source pending in any later stage; R0 never conflicts
    function automatic logic pending(input logic [reg_addr_width-1:0] src);
        logic busy;
        busy = (src == id_ex_rd) || (src == ex_mem_rd) || (src == mem_wb_rd);
        return busy && (src != zero_reg);
    endfunction

    assign hit_1 = pending(src_1);
    assign hit_2 = uses_src_2 && pending(src_2);

    // Stall only a live word not already waiting on a redirect
    assign stall = valid && !pc_hazard && (hit_1 || hit_2);

    // Held from the edge after the flow change until pc_update
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_hazard <= 1'b0;
        end else if (pc_update) begin
            pc_hazard <= 1'b0;
        end else if (valid && !stall && flow_change) begin
            pc_hazard <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
// Instruction decode stage
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic [cpu16_pkg::data_width-1:0]     instr,
    input  wire logic [cpu16_pkg::data_width-1:0]     pc,
    input  wire logic                                valid,
    input  wire logic                                reg_write_in,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] wb_reg,
    input  wire logic [cpu16_pkg::data_width-1:0]     wb_data,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] id_ex_rd,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] ex_mem_rd,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] mem_wb_rd,
    input  wire logic                                pc_update,
    output logic reg_write, mem_write, mem_read, mem_to_reg, alu_src,
    output cpu16_pkg::alu_op_e alu_op,
    output logic branch, call, ret, load_half, half_spec, halt,
    output logic [cpu16_pkg::data_width-1:0]     read_data_1,
    output logic [cpu16_pkg::data_width-1:0]     read_data_2,
    output logic [cpu16_pkg::data_width-1:0]     sign_ext,
    output logic [cpu16_pkg::imm4_w-1:0]         arith_imm,
    output logic [cpu16_pkg::imm8_w-1:0]         ls_imm,
    output logic [cpu16_pkg::rd_w-1:0]           ls_reg,
    output logic [cpu16_pkg::cond_w-1:0]         branch_cond,
    output logic [cpu16_pkg::target_w-1:0]       call_target,
    output logic [cpu16_pkg::data_width-1:0]     pc_out,
    output logic                                 stall,
    output logic                                 pc_hazard
);
    import cpu16_pkg::*;

    opcode_e               opcode;
    logic [rd_w-1:0]       rd_field;
    logic [rs_w-1:0]       rs_field;
    logic [rt_w-1:0]       rt_field;
    logic [imm4_w-1:0]     imm4;
    logic [imm8_w-1:0]     imm8;
    logic [reg_addr_width-1:0] addr_1, addr_2;   // Effective read addresses
    logic [data_width-1:0] rf_data_1, rf_data_2;
    logic                  c_reg_write, c_mem_write, c_mem_read, c_mem_to_reg, c_alu_src;
    alu_op_e               c_alu_op;
    logic                  c_branch, c_call, c_ret, c_load_half, c_half_spec, c_halt;
    logic                  data_reg, stack_reg, rt_src, imm8_sel, reads_rt;
    logic                  bubble;

    // Field split
    assign opcode      = opcode_e'(instr[opcode_lsb +: opcode_w]);
    assign rd_field    = instr[rd_lsb +: rd_w];
    assign rs_field    = instr[rs_lsb +: rs_w];
    assign rt_field    = instr[rt_lsb +: rt_w];
    assign imm4        = instr[imm4_lsb +: imm4_w];
    assign imm8        = instr[imm8_lsb +: imm8_w];
    assign branch_cond = instr[cond_lsb +: cond_w];     // Passes through bubbles
    assign call_target = instr[target_lsb +: target_w];
    assign pc_out      = pc;

    // Port 1 reads DS for memory ops and SP for stack ops
    assign addr_1 = data_reg ? ds_reg : (stack_reg ? sp_reg : rs_field);
    assign addr_2 = rt_src ? rd_field : rt_field;  // SW/LHB/LLB read the dest field

    control_decode u_ctrl (
        .opcode(opcode), .reg_write(c_reg_write), .mem_write(c_mem_write),
        .mem_read(c_mem_read), .mem_to_reg(c_mem_to_reg), .alu_src(c_alu_src),
        .alu_op(c_alu_op), .branch(c_branch), .call(c_call), .ret(c_ret),
        .load_half(c_load_half), .half_spec(c_half_spec), .halt(c_halt),
        .data_reg(data_reg), .stack_reg(stack_reg), .rt_src(rt_src),
        .imm8_sel(imm8_sel), .reads_rt(reads_rt)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .write_en(reg_write_in), .write_reg(wb_reg),
        .write_data(wb_data), .read_reg_1(addr_1), .read_reg_2(addr_2),
        .read_data_1(rf_data_1), .read_data_2(rf_data_2)
    );

    hazard_unit u_hdu (
        .clk(clk), .rst(rst), .src_1(addr_1), .src_2(addr_2), .uses_src_2(reads_rt),
        .valid(valid), .id_ex_rd(id_ex_rd), .ex_mem_rd(ex_mem_rd), .mem_wb_rd(mem_wb_rd),
        .flow_change(c_branch || c_call || c_ret), .pc_update(pc_update),
        .stall(stall), .pc_hazard(pc_hazard)
    );

    assign bubble = stall || pc_hazard || !valid;

    // Bubble mux drives zeros and ALU pass downstream
    always_comb begin
        reg_write   = bubble ? 1'b0 : c_reg_write;
        mem_write   = bubble ? 1'b0 : c_mem_write;
        mem_read    = bubble ? 1'b0 : c_mem_read;
        mem_to_reg  = bubble ? 1'b0 : c_mem_to_reg;
        alu_src     = bubble ? 1'b0 : c_alu_src;
        alu_op      = bubble ? alu_pass : c_alu_op;
        branch      = bubble ? 1'b0 : c_branch;
        call        = bubble ? 1'b0 : c_call;
        ret         = bubble ? 1'b0 : c_ret;
        load_half   = bubble ? 1'b0 : c_load_half;
        half_spec   = bubble ? 1'b0 : c_half_spec;
        halt        = bubble ? 1'b0 : c_halt;
        read_data_1 = bubble ? '0 : rf_data_1;
        read_data_2 = bubble ? '0 : rf_data_2;
        arith_imm   = bubble ? '0 : imm4;
        ls_imm      = bubble ? '0 : imm8;
        ls_reg      = bubble ? '0 : rd_field;
        if (bubble) begin
            sign_ext = '0;
        end else if (imm8_sel) begin
            sign_ext = {{(data_width-imm8_w){imm8[imm8_w-1]}}, imm8};
        end else begin
            sign_ext = {{(data_width-imm4_w){imm4[imm4_w-1]}}, imm4};
        end
    end

endmodule

`default_nettype wire

// File: design/if_id_reg.sv
// IF/ID pipeline register
`timescale 1ns/100ps
`default_nettype none

module if_id_reg (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            stall,      // Data hazard hold
    input  wire logic                            pc_hazard,  // Waiting on redirect
    input  wire logic                            pc_update,  // Redirected word present
    input  wire logic [cpu16_pkg::data_width-1:0] instr,
    input  wire logic [cpu16_pkg::data_width-1:0] pc,
    output logic      [cpu16_pkg::data_width-1:0] id_instr,
    output logic      [cpu16_pkg::data_width-1:0] id_pc,
    output logic                                 id_valid
);
    import cpu16_pkg::*;

    logic load;

    // Redirect always wins over a held word
    assign load = (!stall && !pc_hazard) || pc_update;

    // Instruction word and its PC
    always_ff @(posedge clk) begin
        if (load) begin
            id_instr <= instr;
            id_pc    <= pc;
        end
    end

    // Valid stays low until the first load after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else if (load) begin
            id_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
// Architectural register file
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                write_en,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] write_reg,
    input  wire logic [cpu16_pkg::data_width-1:0]     write_data,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] read_reg_1,
    input  wire logic [cpu16_pkg::reg_addr_width-1:0] read_reg_2,
    output logic      [cpu16_pkg::data_width-1:0]     read_data_1,
    output logic      [cpu16_pkg::data_width-1:0]     read_data_2
);
    import cpu16_pkg::*;

    logic [data_width-1:0] regs [num_regs];

    // Reset clears the file except SP, which starts at top of memory
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            regs[sp_reg] <= sp_reset_value;
        end else if (write_en && (write_reg != zero_reg)) begin
            regs[write_reg] <= write_data;  // R0 stays zero
        end
    end

    // Combinational reads without write-through
    always_comb begin
        if (read_reg_1 == zero_reg) begin
            read_data_1 = '0;
        end else begin
            read_data_1 = regs[read_reg_1];
        end
    end

    always_comb begin
        if (read_reg_2 == zero_reg) begin
            read_data_2 = '0;
        end else begin
            read_data_2 = regs[read_reg_2];
        end
    end

endmodule

`default_nettype wire

// File: verif/decode_chk.sv
// Decode stage assertions
`timescale 1ns/100ps
`default_nettype none

module decode_chk (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               pc_update,
    input wire logic               stall,
    input wire logic               pc_hazard,
    input wire logic               reg_write, mem_write, mem_read, mem_to_reg, alu_src,
    input wire logic               branch, call, ret, load_half, half_spec, halt,
    input wire cpu16_pkg::alu_op_e alu_op
);
    import cpu16_pkg::*;

    logic quiet;  // Bubble on the control outputs

    assign quiet = !(reg_write || mem_write || mem_read || mem_to_reg || alu_src ||
                     branch || call || ret || load_half || half_spec || halt) &&
                   (alu_op == alu_pass);

    // Hazards force a bubble downstream
    bubble_on_hazard: assert property (@(posedge clk) disable iff (rst)
        (stall || pc_hazard) |-> quiet)
        else $error("Control output active during stall or pc_hazard");

    quiet_after_reset: assert property (@(posedge clk) rst |=> quiet)
        else $error("Control output active in the cycle after reset");

    // Redirect wait ends only with pc_update
    hazard_held: assert property (@(posedge clk) disable iff (rst)
        (pc_hazard && !pc_update) |=> pc_hazard)
        else $error("pc_hazard dropped without pc_update");

endmodule

`default_nettype wire

// File: verif/decode_tb.sv
// CPU16 decode testbench
`timescale 1ns/100ps
`default_nettype none

module decode_tb;
    import cpu16_pkg::*;

    localparam int clk_period      = 100;
    localparam int directed_cycles = 70;   // Reset, call, write-back, opcode sweep, hazards
    localparam int random_cycles   = 300;
    localparam int margin_cycles   = 20;

    // Expected values of every DUT output
    typedef struct packed {
        logic        reg_write, mem_write, mem_read, mem_to_reg, alu_src;
        logic [2:0]  alu_op;
        logic        branch, call, ret, load_half, half_spec, halt;
        logic [15:0] read_data_1, read_data_2, sign_ext;
        logic [3:0]  arith_imm;
        logic [7:0]  ls_imm;
        logic [3:0]  ls_reg;
        logic [2:0]  branch_cond;
        logic [11:0] call_target;
        logic [15:0] pc_out;
        logic        stall, pc_hazard;
    } expect_t;

    logic        clk, rst, pc_update, reg_write_in;
    logic [15:0] instr, pc, wb_data;
    logic [3:0]  wb_reg, id_ex_rd, ex_mem_rd, mem_wb_rd;
    logic        reg_write, mem_write, mem_read, mem_to_reg, alu_src;
    alu_op_e     alu_op;
    logic        branch, call, ret, load_half, half_spec, halt, stall, pc_hazard;
    logic [15:0] read_data_1, read_data_2, sign_ext, pc_out;
    logic [3:0]  arith_imm, ls_reg;
    logic [7:0]  ls_imm;
    logic [2:0]  branch_cond;
    logic [11:0] call_target;

    logic [15:0] shadow [num_regs];   // Register file mirror
    logic [15:0] held_instr, held_pc; // IF/ID buffer mirror
    logic        held_valid, held_hazard;
    int          seed = 22;
    int          error_count = 0;

    decode_top UUT (.*);

    bind decode_top decode_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog sized from the test length
    initial begin
        #((directed_cycles + random_cycles + margin_cycles) * clk_period);
        $display("Timeout: the run did not reach its end in the expected number of cycles");
        $display("Errors found");
        $fatal(1);
    end

    function automatic logic register_pending(input logic [3:0] r);
        return (r != 4'd0) && ((r == id_ex_rd) || (r == ex_mem_rd) || (r == mem_wb_rd));
    endfunction

    function automatic logic [3:0] random_hazard_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[4] ? r[3:0] : 4'd0;  // Half the time nothing pending
    endfunction

    // Expected outputs for the held word, shadow registers and hazard state
    function automatic expect_t predict_outputs(input logic [15:0] w, input logic [15:0] p,
                                                input logic v, input logic hz);
        expect_t     e;
        logic [18:0] row;
        logic        use_ds, use_sp, rt_dest, wide, uses_rt, busy;
        logic [3:0]  a1, a2;
        e = '0;
        // rw mw mr m2r | asrc br call ret | lh hs halt ds | sp rtdst imm8 rt_used | alu
        case (w[15:12])
            op_add:  row = {16'b1000_0000_0000_0001, alu_add};
            op_sub:  row = {16'b1000_0000_0000_0001, alu_sub};
            op_nand: row = {16'b1000_0000_0000_0001, alu_nand};
            op_xor:  row = {16'b1000_0000_0000_0001, alu_xor};
            op_addi: row = {16'b1000_1000_0000_0000, alu_add};
            op_sll:  row = {16'b1000_1000_0000_0000, alu_sll};
            op_srl:  row = {16'b1000_1000_0000_0000, alu_srl};
            op_sra:  row = {16'b1000_1000_0000_0000, alu_sra};
            op_lw:   row = {16'b1011_1000_0001_0010, alu_add};
            op_sw:   row = {16'b0100_1000_0001_0111, alu_add};
            op_lhb:  row = {16'b1000_1000_1000_0111, alu_pass};
            op_llb:  row = {16'b1000_1000_1100_0111, alu_pass};
            op_b:    row = {16'b0000_0100_0000_0000, alu_sub};
            op_call: row = {16'b0100_0010_0000_1000, alu_sub};
            op_ret:  row = {16'b0010_0001_0000_1000, alu_add};
            default: row = {16'b0000_0000_0010_0000, alu_pass};  // Halt
        endcase
        {e.reg_write, e.mem_write, e.mem_read, e.mem_to_reg, e.alu_src, e.branch, e.call,
         e.ret, e.load_half, e.half_spec, e.halt, use_ds, use_sp, rt_dest, wide, uses_rt,
         e.alu_op} = row;
        a1 = use_ds ? ds_reg : (use_sp ? sp_reg : w[7:4]);
        a2 = rt_dest ? w[11:8] : w[3:0];
        busy = v && !hz && (register_pending(a1) || (uses_rt && register_pending(a2)));
        e.read_data_1 = shadow[a1];  // Entry 0 never written
        e.read_data_2 = shadow[a2];
        e.sign_ext    = wide ? {{8{w[7]}}, w[7:0]} : {{12{w[3]}}, w[3:0]};
        e.arith_imm   = w[3:0];
        e.ls_imm      = w[7:0];
        e.ls_reg      = w[11:8];
        if (busy || hz || !v) begin
            e = '0;                  // Bubble
            e.alu_op = alu_pass;
        end
        e.branch_cond = w[10:8];     // Pass-through fields
        e.call_target = w[11:0];
        e.pc_out      = p;
        e.stall       = busy;
        e.pc_hazard   = hz;
        return e;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // One fetch cycle of stimulus
    task automatic drive_cycle(input logic [15:0] w, input logic redirect, input logic we,
                               input logic [3:0] wr, input logic [15:0] wd,
                               input logic [3:0] h1, input logic [3:0] h2,
                               input logic [3:0] h3);
        @(posedge clk);
        instr        <= w;
        pc           <= pc + 16'd1;
        pc_update    <= redirect;
        reg_write_in <= we;
        wb_reg       <= wr;
        wb_data      <= wd;
        id_ex_rd     <= h1;
        ex_mem_rd    <= h2;
        mem_wb_rd    <= h3;
    endtask

    task automatic present_word(input logic [15:0] w);
        drive_cycle(w, 1'b0, 1'b0, 4'd0, 16'h0, 4'd0, 4'd0, 4'd0);
    endtask

    // Two words lost to the open hazard before the redirected word
    task automatic redirect_after_flow(input logic [15:0] target);
        present_word({op_hlt, 12'h000});
        present_word({op_hlt, 12'h000});
        drive_cycle(target, 1'b1, 1'b0, 4'd0, 16'h0, 4'd0, 4'd0, 4'd0);
    endtask

    // Compare mid-cycle and advance the model to the next edge
    always @(negedge clk) begin : model_check
        expect_t e;
        logic    load;
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                shadow[i] = 16'h0;
            end
            shadow[sp_reg] = sp_reset_value;
            held_valid     = 1'b0;
            held_hazard    = 1'b0;
            held_instr     = instr;  // Buffer still loads during reset
            held_pc        = pc;
        end else begin
            e = predict_outputs(held_instr, held_pc, held_valid, held_hazard);
            expect_equal("reg_write", reg_write, e.reg_write);
            expect_equal("mem_write", mem_write, e.mem_write);
            expect_equal("mem_read", mem_read, e.mem_read);
            expect_equal("mem_to_reg", mem_to_reg, e.mem_to_reg);
            expect_equal("alu_src", alu_src, e.alu_src);
            expect_equal("alu_op", alu_op, e.alu_op);
            expect_equal("branch", branch, e.branch);
            expect_equal("call", call, e.call);
            expect_equal("ret", ret, e.ret);
            expect_equal("load_half", load_half, e.load_half);
            expect_equal("half_spec", half_spec, e.half_spec);
            expect_equal("halt", halt, e.halt);
            expect_equal("read_data_1", read_data_1, e.read_data_1);
            expect_equal("read_data_2", read_data_2, e.read_data_2);
            expect_equal("sign_ext", sign_ext, e.sign_ext);
            expect_equal("arith_imm", arith_imm, e.arith_imm);
            expect_equal("ls_imm", ls_imm, e.ls_imm);
            expect_equal("ls_reg", ls_reg, e.ls_reg);
            expect_equal("branch_cond", branch_cond, e.branch_cond);
            expect_equal("call_target", call_target, e.call_target);
            expect_equal("pc_out", pc_out, e.pc_out);
            expect_equal("stall", stall, e.stall);
            expect_equal("pc_hazard", pc_hazard, e.pc_hazard);
            load = (!e.stall && !held_hazard) || pc_update;
            if (reg_write_in && (wb_reg != 4'd0)) begin
                shadow[wb_reg] = wb_data;
            end
            if (pc_update) begin
                held_hazard = 1'b0;
            end else if (e.branch || e.call || e.ret) begin
                held_hazard = 1'b1;   // Unbubbled flow change
            end
            if (load) begin
                held_instr = instr;
                held_pc    = pc;
                held_valid = 1'b1;
            end
        end
    end

    initial begin
        logic [15:0] word;
        rst          = 1'b1;
        instr        = 16'h0;
        pc           = 16'h0;
        pc_update    = 1'b0;
        reg_write_in = 1'b0;
        wb_reg       = 4'd0;
        wb_data      = 16'h0;
        id_ex_rd     = 4'd0;
        ex_mem_rd    = 4'd0;
        mem_wb_rd    = 4'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Call right after reset reads SP as all ones
        present_word({op_call, 12'h0a5});
        redirect_after_flow({op_addi, 12'h3c7});

        // Write every register including R0 while reading others
        for (int r = 0; r < num_regs; r++) begin
            drive_cycle({op_add, r[3:0], r[3:0], 4'd15 - r[3:0]}, 1'b0, 1'b1, r[3:0],
                        $random(seed), 4'd0, 4'd0, 4'd0);
        end

        // Opcode sweep with random fields
        for (int op = 0; op < 16; op++) begin
            word = $random(seed);
            word[15:12] = op[3:0];
            present_word(word);
            if ((op == op_b) || (op == op_call) || (op == op_ret)) begin
                redirect_after_flow({op_llb, 12'h5a3});
            end
        end

        // Data hazards from each later stage against one held word
        word = {op_sub, 4'd1, 4'd6, 4'd7};
        present_word(word);                     // Loaded before the hazards appear
        drive_cycle(word, 1'b0, 1'b0, 4'd0, 16'h0, 4'd6, 4'd0, 4'd0);
        drive_cycle(word, 1'b0, 1'b0, 4'd0, 16'h0, 4'd0, 4'd7, 4'd0);
        drive_cycle(word, 1'b0, 1'b0, 4'd0, 16'h0, 4'd0, 4'd0, 4'd6);
        present_word(word);
        present_word(word);
        word = {op_addi, 4'd1, 4'd2, 4'd6};     // rt field not a source
        present_word(word);
        drive_cycle(word, 1'b0, 1'b0, 4'd0, 16'h0, 4'd6, 4'd6, 4'd6);
        word = {op_sw, 4'd9, 8'h84};            // Store data from dest field
        drive_cycle(word, 1'b0, 1'b0, 4'd0, 16'h0, 4'd0, 4'd0, 4'd9);
        drive_cycle(word, 1'b0, 1'b0, 4'd0, 16'h0, 4'd0, 4'd0, 4'd9);
        present_word(word);
        present_word(word);

        // Random mix
        repeat (random_cycles) begin
            word = $random(seed);
            drive_cycle(word, ($random(seed) & 7) == 0, $random(seed), $random(seed),
                        $random(seed), random_hazard_reg(), random_hazard_reg(),
                        random_hazard_reg());
        end

        present_word({op_hlt, 12'h000});
        @(negedge clk);
        #(clk_period / 4);  // Past the last comparison
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
